// ==== logic/imul_pkg.sv ====
/*
 * operand and product widths, data word types for the multiplier
 */

package imul_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------

  // one signed operand as it arrives on the request port
  localparam int operand_width = 32;

  // full product of two operands, no truncation
  localparam int product_width = 2 * operand_width;

  // --------------------------------------------------
  // data words
  // --------------------------------------------------

  // raw two's-complement operand word
  typedef logic [operand_width-1:0] imul_operand_t;

  // product word, also used for the partial product
  // and for the left-shifting multiplicand
  typedef logic [product_width-1:0] imul_product_t;

endpackage

// ==== logic/imul_ctrl_pkg.sv ====
/*
 * controller state encoding and step counter sizing
 */

package imul_ctrl_pkg;

  // one shift-and-add step per multiplier bit
  localparam int imul_steps = imul_pkg::operand_width;

  // counter covers 0 .. imul_steps-1
  localparam int step_count_width = $clog2(imul_steps);

  // --------------------------------------------------
  // controller states
  // --------------------------------------------------

  // idle waits for a request, calc runs the loop,
  // done holds the product until it is taken
  typedef enum logic [1:0] {
    idle = 2'd0,
    calc = 2'd1,
    done = 2'd2
  } imul_state_e;

endpackage

// ==== logic/imul_ctrl.sv ====
/*
 * multiplier controller FSM
 * request/response handshake and datapath strobes
 */

`timescale 1ns/1ps

module imul_ctrl
  import imul_ctrl_pkg::*;
(
  input  logic clk,
  input  logic reset,

  // request side
  input  logic req_val,
  output logic req_rdy,

  // response side
  output logic resp_val,
  input  logic resp_rdy,

  // from step counter
  input  logic step_last,

  // datapath strobes
  output logic load,
  output logic step
);

  imul_state_e state;
  imul_state_e state_next;

  // --------------------------------------------------
  // state register
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  // --------------------------------------------------
  // next state
  // --------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      // accept edge starts the loop
      idle: if (req_val) state_next = calc;
      // leave after the final step has been applied
      calc: if (step_last) state_next = done;
      // hold the product until the taking edge
      done: if (resp_rdy) state_next = idle;
      default: state_next = idle;
    endcase
  end

  // --------------------------------------------------
  // handshake levels and strobes
  // --------------------------------------------------

  // ready only while nothing is in flight
  assign req_rdy = (state == idle);
  assign resp_val = (state == done);

  // one-cycle pulse, true exactly on the accept edge
  assign load = req_rdy & req_val;

  // one step on every calc cycle, no stalls inside the loop
  assign step = (state == calc);

endmodule

// ==== logic/imul_step_counter.sv ====
/*
 * shift-and-add step counter with last-step flag
 */

`timescale 1ns/1ps

module imul_step_counter
  import imul_ctrl_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic load,
  input  logic step,
  output logic step_last
);

  // index of the step being done this cycle
  logic [step_count_width-1:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      // new operation starts at step 0
      count <= '0;
    end else if (step) begin
      // wraps back to 0 after the last step, harmless
      count <= count + 1'b1;
    end
  end

  // last index is imul_steps-1
  assign step_last = (count == step_count_width'(imul_steps - 1));

endmodule

// ==== logic/imul_operand_regs.sv ====
/*
 * operand sign capture, magnitude conversion
 * and multiplicand / multiplier shift registers
 */

`timescale 1ns/1ps

module imul_operand_regs
  import imul_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  logic          load,
  input  logic          step,
  input  imul_operand_t req_a,
  input  imul_operand_t req_b,
  output imul_product_t multiplicand,
  output logic          multiplier_lsb,
  output logic          product_neg
);

  // --------------------------------------------------
  // sign and magnitude of the incoming operands
  // --------------------------------------------------

  logic          sign_a;
  logic          sign_b;
  imul_operand_t mag_a;
  imul_operand_t mag_b;

  assign sign_a = req_a[operand_width-1];
  assign sign_b = req_b[operand_width-1];

  // two's negation when negative
  // most negative value maps onto 2**31, still right as unsigned
  assign mag_a = sign_a ? (~req_a + 1'b1) : req_a;
  assign mag_b = sign_b ? (~req_b + 1'b1) : req_b;

  // --------------------------------------------------
  // shift registers
  // --------------------------------------------------

  imul_product_t multiplicand_q;
  imul_operand_t multiplier_q;
  logic          neg_q;

  // multiplicand moves left one place per step, upper half starts at zero
  always_ff @(posedge clk) begin
    if (load) begin
      multiplicand_q <= {{(product_width - operand_width){1'b0}}, mag_a};
    end else if (step) begin
      multiplicand_q <= multiplicand_q << 1;
    end
  end

  // multiplier moves right, its lsb picks the add
  // reset keeps the lsb low so nothing stray reaches the accumulator
  always_ff @(posedge clk) begin
    if (reset) begin
      multiplier_q <= '0;
      neg_q        <= 1'b0;
    end else if (load) begin
      multiplier_q <= mag_b;
      // product is negative when exactly one operand was
      neg_q        <= sign_a ^ sign_b;
    end else if (step) begin
      multiplier_q <= multiplier_q >> 1;
    end
  end

  assign multiplicand   = multiplicand_q;
  assign multiplier_lsb = multiplier_q[0];
  assign product_neg    = neg_q;

endmodule

// ==== logic/imul_accum.sv ====
/*
 * partial product accumulator and output sign correction
 */

`timescale 1ns/1ps

module imul_accum
  import imul_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  logic          load,
  input  logic          step,
  input  imul_product_t multiplicand,
  input  logic          multiplier_lsb,
  input  logic          product_neg,
  output imul_product_t resp_product
);

  // --------------------------------------------------
  // accumulator
  // --------------------------------------------------

  // unsigned product of the two magnitudes
  imul_product_t acc;
  imul_product_t acc_sum;

  // add only when the current multiplier bit is set
  assign acc_sum = multiplier_lsb ? (acc + multiplicand) : acc;

  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else if (load) begin
      // fresh operation
      acc <= '0;
    end else if (step) begin
      acc <= acc_sum;
    end
  end

  // --------------------------------------------------
  // sign correction
  // --------------------------------------------------

  // acc and product_neg both hold in done, so the
  // result stays stable for as long as resp_val is up
  assign resp_product = product_neg ? (~acc + 1'b1) : acc;

endmodule

// ==== logic/imul_iterative.sv ====
/*
 * iterative 32x32 signed multiplier, top level
 * controller, step counter, operand registers and accumulator
 */

`timescale 1ns/1ps

module imul_iterative
  import imul_pkg::*;
(
  input  logic          clk,
  input  logic          reset,

  // request port
  input  imul_operand_t req_a,
  input  imul_operand_t req_b,
  input  logic          req_val,
  output logic          req_rdy,

  // response port
  output imul_product_t resp_product,
  output logic          resp_val,
  input  logic          resp_rdy
);

  // strobes from the controller
  logic load;
  logic step;

  // loop end flag
  logic step_last;

  // operand registers to accumulator
  imul_product_t multiplicand;
  logic          multiplier_lsb;
  logic          product_neg;

  // --------------------------------------------------
  // control
  // --------------------------------------------------

  imul_ctrl ctrl_inst (
    .clk       (clk),
    .reset     (reset),
    .req_val   (req_val),
    .req_rdy   (req_rdy),
    .resp_val  (resp_val),
    .resp_rdy  (resp_rdy),
    .step_last (step_last),
    .load      (load),
    .step      (step)
  );

  imul_step_counter step_counter_inst (
    .clk       (clk),
    .reset     (reset),
    .load      (load),
    .step      (step),
    .step_last (step_last)
  );

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------

  imul_operand_regs operand_regs_inst (
    .clk            (clk),
    .reset          (reset),
    .load           (load),
    .step           (step),
    .req_a          (req_a),
    .req_b          (req_b),
    .multiplicand   (multiplicand),
    .multiplier_lsb (multiplier_lsb),
    .product_neg    (product_neg)
  );

  imul_accum accum_inst (
    .clk            (clk),
    .reset          (reset),
    .load           (load),
    .step           (step),
    .multiplicand   (multiplicand),
    .multiplier_lsb (multiplier_lsb),
    .product_neg    (product_neg),
    .resp_product   (resp_product)
  );

endmodule

// ==== verification/tb_imul_iterative.sv ====
/*
 * testbench for the iterative signed multiplier
 * vectors from a data file, handshake levels, latency and back-pressure
 */

`timescale 1ns/1ps

module tb_imul_iterative
  import imul_pkg::*;
  import imul_ctrl_pkg::*;
();

  // --------------------------------------------------
  // DUT signals
  // --------------------------------------------------

  logic          clk = 1'b0;
  logic          reset;
  imul_operand_t req_a;
  imul_operand_t req_b;
  logic          req_val;
  logic          req_rdy;
  imul_product_t resp_product;
  logic          resp_val;
  logic          resp_rdy;

  // vectors as read from the data file
  imul_operand_t vec_a[$];
  imul_operand_t vec_b[$];
  imul_product_t vec_product[$];
  int            vec_stall[$];

  // run limit, set once the vectors are known
  int          cycle_count = 0;
  int          cycle_limit = 0;
  int          error_count = 0;
  int unsigned seed_value;

  imul_iterative imul_iterative_inst (
    .clk          (clk),
    .reset        (reset),
    .req_a        (req_a),
    .req_b        (req_b),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .resp_product (resp_product),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy)
  );

  // 20 ns period
  always #10 clk = ~clk;

  // --------------------------------------------------
  // failure reporting and compare tasks
  // --------------------------------------------------

  task automatic stop_with_failure();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic check_product(input string name, input imul_product_t expected,
                               input imul_product_t actual);
    if (actual !== expected) begin
      error_count++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_level(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      error_count++;
      $display("** Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
      stop_with_failure();
    end
  endtask

  // cycles from the accept edge until resp_val is seen high
  task automatic check_latency(input int cycles);
    if (cycles != imul_steps) begin
      error_count++;
      $display("** Error at %0t: resp_val latency expected %0d, got %0d",
               $time, imul_steps, cycles);
      stop_with_failure();
    end
  endtask

  // --------------------------------------------------
  // vector file
  // --------------------------------------------------

  task automatic load_vectors();
    int            fd;
    int            fields;
    string         line;
    imul_operand_t a;
    imul_operand_t b;
    imul_product_t p;
    int            s;
    fd = $fopen("verification/imul_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vector file verification/imul_testdata.txt");
      stop_with_failure();
    end
    while ($fgets(line, fd) != 0) begin
      // blank lines and // comment lines carry no vector
      if (line.len() > 1 && line.substr(0, 1) != "//") begin
        fields = $sscanf(line, "%h %h %h %h", a, b, p, s);
        if (fields != 4) begin
          $display("malformed line in the vector file: %s", line);
          stop_with_failure();
        end
        vec_a.push_back(a);
        vec_b.push_back(b);
        vec_product.push_back(p);
        vec_stall.push_back(s);
      end
    end
    $fclose(fd);
    if (vec_a.size() == 0) begin
      $display("the vector file holds no vectors");
      stop_with_failure();
    end
    // reset cycles plus loop, stall and slack per vector
    cycle_limit = 16;
    foreach (vec_stall[i]) begin
      cycle_limit += imul_steps + vec_stall[i] + 8;
    end
  endtask

  // --------------------------------------------------
  // one request / response pair
  // --------------------------------------------------

  // entered 2 ns after an edge from which the unit is idle,
  // a gap of 0 offers the request right after the previous taking edge
  task automatic run_vector(input int idx);
    int k;
    int gap;
    bit taken;
    bit seen_val;
    gap = $urandom % 4;
    repeat (gap) begin
      @(negedge clk);
      check_level("req_rdy", 1'b1, req_rdy);
      check_level("resp_val", 1'b0, resp_val);
      @(posedge clk);
      #2;
    end
    req_a    = vec_a[idx];
    req_b    = vec_b[idx];
    req_val  = 1'b1;
    resp_rdy = 1'b0;
    // unit must be idle before the accept edge
    @(negedge clk);
    check_level("req_rdy", 1'b1, req_rdy);
    check_level("resp_val", 1'b0, resp_val);
    @(posedge clk);
    k        = 0;
    taken    = 1'b0;
    seen_val = 1'b0;
    while (!taken) begin
      #2;
      // changed operands stay offered while busy, must be ignored
      if (k == 0) begin
        req_a = ~vec_a[idx];
        req_b = vec_b[idx] ^ 32'h5a5a_5a5a;
      end
      // product is taken after the vector's stall cycles
      resp_rdy = (k >= imul_steps + vec_stall[idx]);
      @(negedge clk);
      if (!seen_val) begin
        if (resp_val) begin
          seen_val = 1'b1;
          check_latency(k);
        end else if (k >= imul_steps) begin
          check_level("resp_val", 1'b1, resp_val);
        end
      end else begin
        // back-pressure must not drop the response
        check_level("resp_val", 1'b1, resp_val);
      end
      if (resp_val) begin
        check_product("resp_product", vec_product[idx], resp_product);
      end
      check_level("req_rdy", 1'b0, req_rdy);
      taken = resp_val && resp_rdy;
      @(posedge clk);
      k++;
    end
    // just after the taking edge, inputs back to idle
    #2;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    req_a    = '0;
    req_b    = '0;
  endtask

  // --------------------------------------------------
  // run limit
  // --------------------------------------------------

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: response never arrived");
      stop_with_failure();
    end
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial begin
    reset    = 1'b1;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    seed_value = $urandom(32'ha1b);
    load_vectors();
    repeat (16) @(posedge clk);
    #2 reset = 1'b0;
    // idle levels straight out of reset
    @(negedge clk);
    check_level("req_rdy", 1'b1, req_rdy);
    check_level("resp_val", 1'b0, resp_val);
    @(posedge clk);
    #2;
    foreach (vec_a[i]) begin
      run_vector(i);
    end
    // idle levels in the cycle after the last taking edge
    @(negedge clk);
    check_level("req_rdy", 1'b1, req_rdy);
    check_level("resp_val", 1'b0, resp_val);
    if (error_count == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      stop_with_failure();
    end
  end

endmodule

// ==== verification/imul_testdata.txt ====
// columns: operand a, operand b, expected product, response stall cycles
// all hex, operands and product in two's complement
00000003 00000005 000000000000000F 0
00000007 00000006 000000000000002A 1
0000FFFF 0000FFFF 00000000FFFE0001 2
7FFFFFFF 7FFFFFFF 3FFFFFFF00000001 0
00012345 00000010 0000000000123450 3
00000064 000003E8 00000000000186A0 1
00010000 00010000 0000000100000000 0
00000002 40000000 0000000080000000 5
00000004 40000000 0000000100000000 0
FFFFFFFD 00000005 FFFFFFFFFFFFFFF1 0
00000007 FFFFFFFA FFFFFFFFFFFFFFD6 1
0000000A FFFFFFF6 FFFFFFFFFFFFFF9C 2
FFFF0000 00010000 FFFFFFFF00000000 2
00001000 FFFFF000 FFFFFFFFFF000000 0
0000FFFF FFFF0001 FFFFFFFF0001FFFF 0
FFFFFFFE 40000000 FFFFFFFF80000000 1
FFFFFFFD FFFFFFFB 000000000000000F 2
FFFFFF9C FFFFFF9C 0000000000002710 0
00000000 12345678 0000000000000000 1
87654321 00000000 0000000000000000 0
00000000 80000000 0000000000000000 0
FFFFFFFF 00000000 0000000000000000 2
00000001 FFFFFFFF FFFFFFFFFFFFFFFF 0
FFFFFFFF 00000001 FFFFFFFFFFFFFFFF 4
FFFFFFFF FFFFFFFF 0000000000000001 0
00000001 12345678 0000000012345678 0
FFFFFFFF 12345678 FFFFFFFFEDCBA988 1
7FFFFFFF FFFFFFFF FFFFFFFF80000001 1
80000000 80000000 4000000000000000 2
80000000 FFFFFFFF 0000000080000000 0
FFFFFFFF 80000000 0000000080000000 3
80000000 00000001 FFFFFFFF80000000 0
80000000 7FFFFFFF C000000080000000 1
7FFFFFFF 80000000 C000000080000000 0

// ==== tb.f ====
logic/imul_pkg.sv
logic/imul_ctrl_pkg.sv
logic/imul_ctrl.sv
logic/imul_step_counter.sv
logic/imul_operand_regs.sv
logic/imul_accum.sv
logic/imul_iterative.sv
verification/tb_imul_iterative.sv

// ==== Bender.yml ====
package:
  name: imul_iterative

sources:
  # design, packages first
  - files:
      - logic/imul_pkg.sv
      - logic/imul_ctrl_pkg.sv
      - logic/imul_ctrl.sv
      - logic/imul_step_counter.sv
      - logic/imul_operand_regs.sv
      - logic/imul_accum.sv
      - logic/imul_iterative.sv

  # testbench
  - target: test
    files:
      - verification/tb_imul_iterative.sv
